//--- poly_butterfly_core.f
kyber_pkg.sv
bf_lane_if.sv
delay_line.sv
mont_mul.sv
butterfly_unit.sv
lane_router.sv
poly_butterfly_core.sv
poly_butterfly_core_asserts.sv
tb_poly_butterfly_core.sv

//--- Bender.yml
package:
  name: poly_butterfly_core

sources:
  - files:
      - kyber_pkg.sv
      - bf_lane_if.sv
      - delay_line.sv
      - mont_mul.sv
      - butterfly_unit.sv
      - lane_router.sv
      - poly_butterfly_core.sv
  - target: test
    files:
      - poly_butterfly_core_asserts.sv
      - tb_poly_butterfly_core.sv

//--- tb_poly_butterfly_core.sv
/*
 * Testbench for the butterfly datapath
 * Stimulus table with expected words from a reference model,
 * one row per cycle, results compared after the pipeline latency
 */
`timescale 1ns/1ps

module tb_poly_butterfly_core;

    localparam int NUM_ROWS = 40;
    localparam int RST_CYC  = 3;
    localparam int MAX_CYC  = RST_CYC + NUM_ROWS + kyber_pkg::BF_LAT + 20;
    localparam int QM       = kyber_pkg::Q;

    typedef struct {
        kyber_pkg::bf_mode_e mode;
        kyber_pkg::layer_t   layer;
        kyber_pkg::word_t    a0, a1, b0, b1;
        kyber_pkg::coef_t    tw0, tw1;
        kyber_pkg::word_t    c0, c1, d0, d1;    // Expected
    } row_t;

    logic                clk;
    logic                rst;
    kyber_pkg::bf_mode_e mode;
    kyber_pkg::layer_t   layer;
    kyber_pkg::word_t    a0, a1, b0, b1;
    kyber_pkg::coef_t    tw0, tw1;
    kyber_pkg::word_t    c0, c1, d0, d1;

    row_t stim [NUM_ROWS];
    int   inflight [$];     // Row indices in the pipeline
    int   inv_r;            // 4096^-1 mod Q
    int   cycles;
    int   pass_cnt;
    int   fail_cnt;
    int   row_err;

    poly_butterfly_core i_dut (
        .clk(clk), .rst(rst), .mode(mode), .layer(layer),
        .a0(a0), .a1(a1), .b0(b0), .b1(b1), .tw0(tw0), .tw1(tw1),
        .c0(c0), .c1(c1), .d0(d0), .d1(d1)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////
    // Reference model
    ////////////////////
    function automatic kyber_pkg::coef_t coef_hi(kyber_pkg::word_t v);
        return v[kyber_pkg::WORD_W-1:kyber_pkg::COEF_W];
    endfunction

    function automatic kyber_pkg::coef_t coef_lo(kyber_pkg::word_t v);
        return v[kyber_pkg::COEF_W-1:0];
    endfunction

    function automatic kyber_pkg::word_t pack_pair(int hi, int lo);
        return {kyber_pkg::coef_t'(hi), kyber_pkg::coef_t'(lo)};
    endfunction

    function automatic int mont_product(int p, int q);
        return (((p * q) % QM) * inv_r) % QM;
    endfunction

    function automatic int halve_mod(int v);
        if (v % 2 == 0) begin
            return v / 2;
        end
        return (v + QM) / 2;
    endfunction

    function automatic row_t with_expected(row_t r);
        int a [4];
        int b [4];
        int w [4];
        int x [4];
        int y [4];
        int t;
        a[0] = coef_hi(r.a0);
        a[1] = coef_lo(r.a0);
        b[2] = coef_hi(r.b1);
        b[3] = coef_lo(r.b1);
        if (r.layer == 1'b0) begin
            a[2] = coef_hi(r.a1);
            a[3] = coef_lo(r.a1);
            b[0] = coef_hi(r.b0);
            b[1] = coef_lo(r.b0);
            w    = '{r.tw0, r.tw0, r.tw0, r.tw0};
        end else begin
            b[0] = coef_hi(r.a1);
            b[1] = coef_lo(r.a1);
            a[2] = coef_hi(r.b0);
            a[3] = coef_lo(r.b0);
            w    = '{r.tw0, r.tw0, r.tw1, r.tw1};
        end
        for (int i = 0; i < 4; i++) begin
            if (r.mode == kyber_pkg::MODE_INTT) begin
                x[i] = halve_mod((a[i] + b[i]) % QM);
                y[i] = mont_product(halve_mod((a[i] - b[i] + QM) % QM), w[i]);
            end else begin
                t    = mont_product(b[i], w[i]);
                x[i] = (a[i] + t) % QM;
                y[i] = (a[i] - t + QM) % QM;
            end
        end
        r.c0 = pack_pair(x[0], x[1]);
        r.d1 = pack_pair(y[2], y[3]);
        if (r.layer == 1'b0) begin
            r.c1 = pack_pair(x[2], x[3]);
            r.d0 = pack_pair(y[0], y[1]);
        end else begin
            r.c1 = pack_pair(y[0], y[1]);
            r.d0 = pack_pair(x[2], x[3]);
        end
        if (r.mode == kyber_pkg::MODE_IDLE) begin
            r.c0 = '0;
            r.c1 = '0;
            r.d0 = '0;
            r.d1 = '0;
        end
        return r;
    endfunction

    function automatic kyber_pkg::coef_t random_coef();
        return kyber_pkg::coef_t'($urandom % QM);
    endfunction

    task automatic build_stim();
        row_t r;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r.a0    = pack_pair(random_coef(), random_coef());
            r.a1    = pack_pair(random_coef(), random_coef());
            r.b0    = pack_pair(random_coef(), random_coef());
            r.b1    = pack_pair(random_coef(), random_coef());
            r.tw0   = random_coef();
            r.tw1   = random_coef();
            r.layer = kyber_pkg::layer_t'(i % 2);
            if (i < 20) begin
                r.mode  = kyber_pkg::MODE_NTT;
                r.layer = (i >= 12);
            end else if (i < 28) begin
                r.mode = kyber_pkg::MODE_INTT;
            end else begin
                case (i % 3)        // Mode and layer both change every row
                    0:       r.mode = kyber_pkg::MODE_NTT;
                    1:       r.mode = kyber_pkg::MODE_INTT;
                    default: r.mode = kyber_pkg::MODE_IDLE;
                endcase
            end
            stim[i] = r;
        end
        // Twiddle of one with the edge values 0 and Q-1
        for (int i = 0; i < 2; i++) begin
            stim[i].layer = kyber_pkg::layer_t'(i);
            stim[i].a0    = pack_pair(0, QM - 1);
            stim[i].a1    = pack_pair(QM - 1, QM - 1);
            stim[i].b0    = pack_pair(QM - 1, 0);
            stim[i].b1    = pack_pair(0, 0);
            stim[i].tw0   = kyber_pkg::MONT_ONE;
            stim[i].tw1   = kyber_pkg::MONT_ONE;
        end
        stim[2].mode = kyber_pkg::MODE_IDLE;
        stim[3].mode = kyber_pkg::MODE_IDLE;
        for (int i = 0; i < NUM_ROWS; i++) begin
            stim[i] = with_expected(stim[i]);
        end
    endtask

    ////////////////////
    // Checks
    ////////////////////
    task automatic check_word(string name, kyber_pkg::word_t got, kyber_pkg::word_t expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
            row_err++;
        end
    endtask

    task automatic check_coef(string name, kyber_pkg::coef_t got);
        if (got >= kyber_pkg::Q) begin
            $display("Coefficient %s is 0x%h and not reduced below the modulus", name, got);
            row_err++;
        end
    endtask

    task automatic check_outputs(kyber_pkg::word_t e_c0, kyber_pkg::word_t e_c1,
                                 kyber_pkg::word_t e_d0, kyber_pkg::word_t e_d1);
        row_err = 0;
        check_word("c0", c0, e_c0);
        check_word("c1", c1, e_c1);
        check_word("d0", d0, e_d0);
        check_word("d1", d1, e_d1);
        check_coef("c0 high", coef_hi(c0));
        check_coef("c0 low", coef_lo(c0));
        check_coef("c1 high", coef_hi(c1));
        check_coef("c1 low", coef_lo(c1));
        check_coef("d0 high", coef_hi(d0));
        check_coef("d0 low", coef_lo(d0));
        check_coef("d1 high", coef_hi(d1));
        check_coef("d1 low", coef_lo(d1));
        if (row_err == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    task automatic apply_row(row_t r);
        mode  = r.mode;
        layer = r.layer;
        a0    = r.a0;
        a1    = r.a1;
        b0    = r.b0;
        b1    = r.b1;
        tw0   = r.tw0;
        tw1   = r.tw1;
    endtask

    initial begin
        void'($urandom(32'hf6ba_bbe5));
        clk      = 1'b0;
        rst      = 1'b0;
        mode     = kyber_pkg::MODE_IDLE;
        layer    = 1'b0;
        a0       = '0;
        a1       = '0;
        b0       = '0;
        b1       = '0;
        tw0      = '0;
        tw1      = '0;
        cycles   = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        inv_r    = 0;
        for (int r = 1; r < QM; r++) begin
            if (((1 << kyber_pkg::MONT_R_BITS) * r) % QM == 1) begin
                inv_r = r;
            end
        end
        build_stim();

        repeat (RST_CYC) @(negedge clk);
        rst = 1'b1;

        for (int n = 0; n < NUM_ROWS + kyber_pkg::BF_LAT; n++) begin
            @(negedge clk);
            if (n < kyber_pkg::BF_LAT) begin
                check_outputs('0, '0, '0, '0);  // Pipeline still empty
                $display("after reset, cycle %0d: %s", n, row_err == 0 ? "ok" : "FAILED");
            end else begin
                row_t r;
                r = stim[inflight.pop_front()];
                check_outputs(r.c0, r.c1, r.d0, r.d1);
                $display("row %0d %s layer %0d: %s", n - kyber_pkg::BF_LAT, r.mode.name(),
                         r.layer, row_err == 0 ? "ok" : "FAILED");
            end
            if (n < NUM_ROWS) begin
                apply_row(stim[n]);
                inflight.push_back(n);
            end else begin
                mode = kyber_pkg::MODE_IDLE;
            end
        end

        $display("%0d checks passed, %0d checks failed, %0d assertion failures",
                 pass_cnt, fail_cnt, i_dut.i_asserts.err_cnt);
        if (fail_cnt == 0 && i_dut.i_asserts.err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- poly_butterfly_core_asserts.sv
/*
 * Concurrent checks on the butterfly top level
 * Cleared outputs after reset and for idle items, reduced coefficients
 */
`timescale 1ns/1ps

module poly_butterfly_core_asserts (
    input logic                clk,
    input logic                rst,
    input kyber_pkg::bf_mode_e mode,
    input kyber_pkg::word_t    c0,
    input kyber_pkg::word_t    c1,
    input kyber_pkg::word_t    d0,
    input kyber_pkg::word_t    d1
);

    function automatic logic reduced(kyber_pkg::word_t v);
        return (v[kyber_pkg::WORD_W-1:kyber_pkg::COEF_W] < kyber_pkg::Q) &&
               (v[kyber_pkg::COEF_W-1:0] < kyber_pkg::Q);
    endfunction

    logic        all_zero;
    logic        all_reduced;
    int unsigned err_cnt = 0;   // Failed assertions

    assign all_zero    = (c0 == '0) && (c1 == '0) && (d0 == '0) && (d1 == '0);
    assign all_reduced = reduced(c0) && reduced(c1) && reduced(d0) && reduced(d1);

    // Reset within the last BF_LAT cycles leaves the pipeline empty
    zero_after_reset: assert property (@(posedge clk)
        rst && !$past(rst, kyber_pkg::BF_LAT) |-> all_zero)
        else begin
            err_cnt++;
            $error("outputs not zero within BF_LAT cycles of reset");
        end

    out_reduced: assert property (@(posedge clk) disable iff (!rst) all_reduced)
        else begin
            err_cnt++;
            $error("output coefficient not below Q");
        end

    idle_gives_zero: assert property (@(posedge clk) disable iff (!rst)
        $past(mode, kyber_pkg::BF_LAT) == kyber_pkg::MODE_IDLE |-> all_zero)
        else begin
            err_cnt++;
            $error("idle item produced nonzero outputs");
        end

endmodule

bind poly_butterfly_core poly_butterfly_core_asserts i_asserts (
    .clk  (clk),
    .rst  (rst),
    .mode (mode),
    .c0   (c0),
    .c1   (c1),
    .d0   (d0),
    .d1   (d1)
);

//--- poly_butterfly_core.sv
/*
 * Top level of the butterfly datapath
 * Router plus four parallel butterfly lanes
 */
`timescale 1ns/1ps

module poly_butterfly_core (
    input  logic                clk,
    input  logic                rst,
    input  kyber_pkg::bf_mode_e mode,
    input  kyber_pkg::layer_t   layer,
    input  kyber_pkg::word_t    a0,
    input  kyber_pkg::word_t    a1,
    input  kyber_pkg::word_t    b0,
    input  kyber_pkg::word_t    b1,
    input  kyber_pkg::coef_t    tw0,
    input  kyber_pkg::coef_t    tw1,
    output kyber_pkg::word_t    c0,
    output kyber_pkg::word_t    c1,
    output kyber_pkg::word_t    d0,
    output kyber_pkg::word_t    d1
);

    bf_lane_if lanes ();

    lane_router i_router (
        .clk   (clk),
        .rst   (rst),
        .mode  (mode),
        .layer (layer),
        .a0    (a0),
        .a1    (a1),
        .b0    (b0),
        .b1    (b1),
        .tw0   (tw0),
        .tw1   (tw1),
        .c0    (c0),
        .c1    (c1),
        .d0    (d0),
        .d1    (d1),
        .lanes (lanes.router)
    );

    ////////////////////
    // Butterfly lanes
    ////////////////////
    for (genvar i = 0; i < kyber_pkg::LANES; i++) begin : g_lane
        butterfly_unit i_bf (
            .clk  (clk),
            .rst  (rst),
            .idx  (i),
            .lane (lanes.lane)
        );
    end

endmodule

//--- lane_router.sv
/*
 * Word to lane routing for layer 0 and layer 1 pairings
 * Repacks lane results in place using delayed mode and layer tags
 */
`timescale 1ns/1ps

module lane_router (
    input  logic                clk,
    input  logic                rst,
    input  kyber_pkg::bf_mode_e mode,
    input  kyber_pkg::layer_t   layer,
    input  kyber_pkg::word_t    a0,
    input  kyber_pkg::word_t    a1,
    input  kyber_pkg::word_t    b0,
    input  kyber_pkg::word_t    b1,
    input  kyber_pkg::coef_t    tw0,
    input  kyber_pkg::coef_t    tw1,
    output kyber_pkg::word_t    c0,
    output kyber_pkg::word_t    c1,
    output kyber_pkg::word_t    d0,
    output kyber_pkg::word_t    d1,
    bf_lane_if.router           lanes
);

    kyber_pkg::bf_mode_e mode_d;
    kyber_pkg::layer_t   layer_d;

    ////////////////////
    // Unpack
    ////////////////////
    always_comb begin
        for (int i = 0; i < kyber_pkg::LANES; i++) begin
            lanes.a[i] = '0;
            lanes.b[i] = '0;
            lanes.w[i] = '0;
        end
        lanes.is_intt = '0;
        if (mode != kyber_pkg::MODE_IDLE) begin
            lanes.is_intt = {kyber_pkg::LANES{mode == kyber_pkg::MODE_INTT}};
            {lanes.a[0], lanes.a[1]} = a0;      // High half to the lower lane
            {lanes.b[2], lanes.b[3]} = b1;
            lanes.w[0] = tw0;
            lanes.w[1] = tw0;
            if (layer == 1'b0) begin
                {lanes.a[2], lanes.a[3]} = a1;
                {lanes.b[0], lanes.b[1]} = b0;
                lanes.w[2] = tw0;
                lanes.w[3] = tw0;
            end else begin
                {lanes.b[0], lanes.b[1]} = a1;
                {lanes.a[2], lanes.a[3]} = b0;
                lanes.w[2] = tw1;
                lanes.w[3] = tw1;
            end
        end
    end

    // Tags travel alongside the butterfly pipeline
    delay_line #(.T(kyber_pkg::bf_mode_e), .DEPTH(kyber_pkg::BF_LAT)) i_mode_dly (
        .clk(clk), .rst(rst), .din(mode), .dout(mode_d)
    );

    delay_line #(.T(kyber_pkg::layer_t), .DEPTH(kyber_pkg::BF_LAT)) i_layer_dly (
        .clk(clk), .rst(rst), .din(layer), .dout(layer_d)
    );

    ////////////////////
    // Repack
    ////////////////////
    always_comb begin
        c0 = '0;
        c1 = '0;
        d0 = '0;
        d1 = '0;
        if (mode_d != kyber_pkg::MODE_IDLE) begin
            c0 = {lanes.x[0], lanes.x[1]};
            d1 = {lanes.y[2], lanes.y[3]};
            if (layer_d == 1'b0) begin
                c1 = {lanes.x[2], lanes.x[3]};
                d0 = {lanes.y[0], lanes.y[1]};
            end else begin
                c1 = {lanes.y[0], lanes.y[1]};    // Back to the a1 slot
                d0 = {lanes.x[2], lanes.x[3]};
            end
        end
    end

endmodule

//--- butterfly_unit.sv
/*
 * One butterfly lane
 * NTT is Cooley-Tukey with a Montgomery multiply,
 * INTT is Gentleman-Sande with halving
 */
`timescale 1ns/1ps

module butterfly_unit (
    input  logic    clk,
    input  logic    rst,
    input  int      idx,        // Lane slot in the bundle
    bf_lane_if.lane lane
);

    kyber_pkg::coef_t op_a;
    kyber_pkg::coef_t op_m;     // Multiplier operand
    kyber_pkg::coef_t op_a_q;
    kyber_pkg::coef_t op_m_q;
    kyber_pkg::coef_t w_q;
    logic             intt_q;
    kyber_pkg::coef_t a_d;
    kyber_pkg::coef_t t;
    logic             intt_d;
    kyber_pkg::coef_t bf_x;
    kyber_pkg::coef_t bf_y;

    function automatic kyber_pkg::coef_t add_mod(input kyber_pkg::coef_t u,
                                                 input kyber_pkg::coef_t v);
        logic [kyber_pkg::COEF_W:0] s;
        s = u + v;
        if (s >= kyber_pkg::Q) begin
            s = s - kyber_pkg::Q;
        end
        return s[kyber_pkg::COEF_W-1:0];
    endfunction

    function automatic kyber_pkg::coef_t sub_mod(input kyber_pkg::coef_t u,
                                                 input kyber_pkg::coef_t v);
        logic [kyber_pkg::COEF_W:0] d;
        if (u >= v) begin
            d = u - v;
        end else begin
            d = u + kyber_pkg::Q - v;
        end
        return d[kyber_pkg::COEF_W-1:0];
    endfunction

    // v/2 mod Q, odd values borrow one Q first
    function automatic kyber_pkg::coef_t half_mod(input kyber_pkg::coef_t v);
        logic [kyber_pkg::COEF_W:0] s;
        s = v[0] ? v + kyber_pkg::Q : {1'b0, v};
        return s[kyber_pkg::COEF_W:1];
    endfunction

    ////////////////////
    // Front stage
    ////////////////////
    always_comb begin
        if (lane.is_intt[idx]) begin
            op_a = half_mod(add_mod(lane.a[idx], lane.b[idx]));
            op_m = half_mod(sub_mod(lane.a[idx], lane.b[idx]));
        end else begin
            op_a = lane.a[idx];
            op_m = lane.b[idx];
        end
    end

    // Both modes enter the multiplier in the same slot, so modes may alternate
    always_ff @(posedge clk) begin
        if (!rst) begin
            op_a_q <= '0;
            op_m_q <= '0;
            w_q    <= '0;
            intt_q <= 1'b0;
        end else begin
            op_a_q <= op_a;
            op_m_q <= op_m;
            w_q    <= lane.w[idx];
            intt_q <= lane.is_intt[idx];
        end
    end

    mont_mul i_mul (.clk(clk), .rst(rst), .a(op_m_q), .b(w_q), .p(t));

    delay_line #(.T(kyber_pkg::coef_t), .DEPTH(kyber_pkg::MUL_LAT)) i_a_dly (
        .clk(clk), .rst(rst), .din(op_a_q), .dout(a_d)
    );

    delay_line #(.T(logic), .DEPTH(kyber_pkg::MUL_LAT)) i_tag_dly (
        .clk(clk), .rst(rst), .din(intt_q), .dout(intt_d)
    );

    ////////////////////
    // Back stage
    ////////////////////
    always_comb begin
        if (intt_d) begin
            bf_x = a_d;     // Halved sum
            bf_y = t;
        end else begin
            bf_x = add_mod(a_d, t);
            bf_y = sub_mod(a_d, t);
        end
    end

    // Each unit writes only its own slot
    always @(*) begin
        lane.x[idx] = bf_x;
        lane.y[idx] = bf_y;
    end

endmodule

//--- mont_mul.sv
/*
 * Pipelined Montgomery multiplier modulo Q, R = 2^12
 * Product, reduction multiple, then shift with one correction
 */
`timescale 1ns/1ps

module mont_mul (
    input  logic             clk,
    input  logic             rst,
    input  kyber_pkg::coef_t a,
    input  kyber_pkg::coef_t b,
    output kyber_pkg::coef_t p
);

    logic [2*kyber_pkg::COEF_W-1:0]    prod_q;     // Full product
    logic [kyber_pkg::MONT_R_BITS-1:0] m;          // Reduction multiple
    logic [2*kyber_pkg::COEF_W:0]      red;
    logic [2*kyber_pkg::COEF_W:0]      red_q;
    logic [kyber_pkg::COEF_W:0]        r;          // Below 2Q for inputs below Q

    // m = -prod * Q^-1 mod R, so prod + m*Q is a multiple of R
    always_comb begin
        m   = prod_q[kyber_pkg::MONT_R_BITS-1:0] * kyber_pkg::QINV_NEG;
        red = prod_q + m * kyber_pkg::Q;
    end

    assign r = red_q[2*kyber_pkg::COEF_W:kyber_pkg::MONT_R_BITS];  // Low bits cancel

    ////////////////////
    // Pipeline
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            prod_q <= '0;
            red_q  <= '0;
            p      <= '0;
        end else begin
            prod_q <= a * b;
            red_q  <= red;
            if (r >= kyber_pkg::Q) begin
                p <= kyber_pkg::coef_t'(r - kyber_pkg::Q);
            end else begin
                p <= r[kyber_pkg::COEF_W-1:0];
            end
        end
    end

endmodule

//--- delay_line.sv
/*
 * Shift register of DEPTH stages for any payload type
 */
`timescale 1ns/1ps

module delay_line #(
    parameter type         T     = logic,
    parameter int unsigned DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    T stage [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= T'(0);
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

//--- bf_lane_if.sv
/*
 * Lane bundle between the router and the four butterflies
 * Operands, twiddle and mode bit in, butterfly results out
 */
`timescale 1ns/1ps

interface bf_lane_if;

    kyber_pkg::coef_t              a [kyber_pkg::LANES];
    kyber_pkg::coef_t              b [kyber_pkg::LANES];
    kyber_pkg::coef_t              w [kyber_pkg::LANES];   // Twiddle per lane
    logic [kyber_pkg::LANES-1:0]   is_intt;

    kyber_pkg::coef_t              x [kyber_pkg::LANES];
    kyber_pkg::coef_t              y [kyber_pkg::LANES];

    modport router (output a, b, w, is_intt, input x, y);
    modport lane (input a, b, w, is_intt, output x, y);

endinterface

//--- kyber_pkg.sv
/*
 * Shared definitions for the Kyber butterfly datapath
 * Modulus, coefficient and word widths, Montgomery constants,
 * pipeline latencies, mode and layer types
 */
package kyber_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int unsigned COEF_W      = 12;
    localparam int unsigned WORD_W      = 2 * COEF_W;   // Two coefficients per word
    localparam int unsigned LANES       = 4;
    localparam int unsigned MONT_R_BITS = 12;           // R = 2^12

    typedef logic [COEF_W-1:0] coef_t;
    typedef logic [WORD_W-1:0] word_t;

    ////////////////////
    // Arithmetic
    ////////////////////
    localparam coef_t                  Q        = 12'd3329;
    localparam logic [MONT_R_BITS-1:0] QINV_NEG = 12'd3327;  // -Q^-1 mod 2^12
    localparam coef_t                  MONT_ONE = 12'd767;   // 2^12 mod Q

    // Pipeline depths
    localparam int unsigned MUL_LAT = 3;
    localparam int unsigned BF_LAT  = 4;

    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_NTT  = 2'd1,
        MODE_INTT = 2'd2
    } bf_mode_e;

    // 0 pairs a words with b words, 1 pairs word 0 with word 1
    typedef logic layer_t;

endpackage
